/* flist.f */
+incdir+.
scratchpad_pkg.sv
scratchpad_mem.sv
tagged_store_queue.sv
store_pair_unit.sv
mem_error_monitor.sv
scratchpad_top.sv
scratchpad_properties.sv
tb_scratchpad.sv

/* mem_error_monitor.sv */
`timescale 1ns/1ps

`include "scratchpad_cfg.svh"

`default_nettype none

module mem_error_monitor (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ld_valid,
  input  scratchpad_pkg::tag_t      ld_tag,
  input  logic                      st_addr_valid,
  input  scratchpad_pkg::tag_t      st_addr_tag,
  input  logic                      st_data_valid,
  input  scratchpad_pkg::tag_t      st_data_tag,
  input  logic                      deadlock,
  output logic                      error_valid,
  output scratchpad_pkg::err_code_t error_code
);

  logic                      tag_oob;
  logic                      err_detect;
  scratchpad_pkg::err_code_t err_next;

  // --------------------------------------------------
  // Tag range checks on valid alone
  // --------------------------------------------------
  assign tag_oob = (ld_valid && int'(ld_tag) >= `SP_LD_COUNT) ||
                   (st_addr_valid && int'(st_addr_tag) >= `SP_ST_COUNT) ||
                   (st_data_valid && int'(st_data_tag) >= `SP_ST_COUNT);

  // Tag error outranks deadlock
  always_comb begin
    err_detect = 1'b1;
    if (tag_oob) begin
      err_next = scratchpad_pkg::ERR_TAG_OOB;
    end else if (deadlock) begin
      err_next = scratchpad_pkg::ERR_STORE_DEADLOCK;
    end else begin
      err_detect = 1'b0;
      err_next   = scratchpad_pkg::ERR_NONE;
    end
  end

  // First error sticks until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= scratchpad_pkg::ERR_NONE;
    end else if (!error_valid && err_detect) begin
      error_valid <= 1'b1;
      error_code  <= err_next;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the scratchpad testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_scratchpad \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

/* scratchpad_cfg.svh */
`ifndef SCRATCHPAD_CFG_SVH
`define SCRATCHPAD_CFG_SVH

`default_nettype none

// Request field widths
`define SP_ADDR_WIDTH 16
`define SP_ELEM_WIDTH 32
`define SP_TAG_WIDTH 2

// Tags in use per direction
`define SP_LD_COUNT 3
`define SP_ST_COUNT 2

// Storage sizes
`define SP_LSQ_DEPTH 4
`define SP_MEM_DEPTH 64

// Cycles a half-filled store tag may wait before it counts as deadlocked
`define SP_DEADLOCK_TIMEOUT 64

`default_nettype wire

`endif

/* scratchpad_mem.sv */
`timescale 1ns/1ps

`include "scratchpad_cfg.svh"

`default_nettype none

module scratchpad_mem (
  input  logic                     clk,
  input  logic                     wr_en,
  input  scratchpad_pkg::mem_idx_t wr_idx,
  input  scratchpad_pkg::elem_t    wr_data,
  input  scratchpad_pkg::mem_idx_t rd_idx,
  output scratchpad_pkg::elem_t    rd_data
);

  localparam int DEPTH = `SP_MEM_DEPTH;

  // --------------------------------------------------
  // Storage array
  // --------------------------------------------------
  scratchpad_pkg::elem_t mem [DEPTH];

  // Single write port, driven by the store pairing unit
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------
  // Zero-latency read, so a load sees the array as of this cycle
  // and a same-cycle store shows up only on the next one
  assign rd_data = mem[rd_idx];

endmodule

`default_nettype wire

/* scratchpad_pkg.sv */
`include "scratchpad_cfg.svh"

`default_nettype none

package scratchpad_pkg;

  // --------------------------------------------------
  // Payload and index types
  // --------------------------------------------------
  typedef logic [`SP_ELEM_WIDTH-1:0] elem_t;

  // Memory index is the low part of the address field
  typedef logic [$clog2(`SP_MEM_DEPTH)-1:0] mem_idx_t;

  typedef logic [`SP_TAG_WIDTH-1:0] tag_t;

  // --------------------------------------------------
  // Error reporting
  // --------------------------------------------------
  typedef logic [15:0] err_code_t;

  localparam err_code_t ERR_NONE           = 16'd0;
  localparam err_code_t ERR_TAG_OOB        = 16'd1;
  localparam err_code_t ERR_STORE_DEADLOCK = 16'd2;

endpackage

`default_nettype wire

/* scratchpad_properties.sv */
`timescale 1ns/1ps

`include "scratchpad_cfg.svh"

`default_nettype none

module scratchpad_properties (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      ld_addr_valid,
  input logic                      ld_addr_ready,
  input logic                      st_done_valid,
  input scratchpad_pkg::tag_t      st_done_data,
  input logic                      error_valid,
  input scratchpad_pkg::err_code_t error_code
);

  // --------------------------------------------------
  // Load handshake
  // --------------------------------------------------
  ld_ready_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n) ld_addr_ready |-> ld_addr_valid
  ) else $error("ld_addr_ready high without ld_addr_valid");

  // Sticky error holds its code until reset
  error_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) error_valid |=> error_valid && $stable(error_code)
  ) else $error("error register changed after it was set");

  // --------------------------------------------------
  // Store completion
  // --------------------------------------------------
  done_tag_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) st_done_valid |-> int'(st_done_data) < `SP_ST_COUNT
  ) else $error("st_done_data outside the store tag range");

endmodule

bind scratchpad_top scratchpad_properties i_scratchpad_properties (
  .clk           (clk),
  .rst_n         (rst_n),
  .ld_addr_valid (ld_addr_valid),
  .ld_addr_ready (ld_addr_ready),
  .st_done_valid (st_done_valid),
  .st_done_data  (st_done_data),
  .error_valid   (error_valid),
  .error_code    (error_code)
);

`default_nettype wire

/* scratchpad_top.sv */
`timescale 1ns/1ps

`include "scratchpad_cfg.svh"

`default_nettype none

module scratchpad_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Load request and responses
  input  logic                                   ld_addr_valid,
  output logic                                   ld_addr_ready,
  input  logic [`SP_TAG_WIDTH+`SP_ADDR_WIDTH-1:0] ld_addr_data,
  output logic                                   ld_data_valid,
  input  logic                                   ld_data_ready,
  output logic [`SP_TAG_WIDTH+`SP_ELEM_WIDTH-1:0] ld_data_data,
  output logic                                   ld_done_valid,
  input  logic                                   ld_done_ready,
  output scratchpad_pkg::tag_t                   ld_done_data,
  // Store streams and completion
  input  logic                                   st_addr_valid,
  output logic                                   st_addr_ready,
  input  logic [`SP_TAG_WIDTH+`SP_ADDR_WIDTH-1:0] st_addr_data,
  input  logic                                   st_data_valid,
  output logic                                   st_data_ready,
  input  logic [`SP_TAG_WIDTH+`SP_ELEM_WIDTH-1:0] st_data_data,
  output logic                                   st_done_valid,
  input  logic                                   st_done_ready,
  output scratchpad_pkg::tag_t                   st_done_data,
  // Sticky error
  output logic                                   error_valid,
  output scratchpad_pkg::err_code_t              error_code
);

  localparam int NTAG  = `SP_ST_COUNT;
  localparam int AW    = `SP_ADDR_WIDTH;
  localparam int EW    = `SP_ELEM_WIDTH;
  localparam int IDX_W = $bits(scratchpad_pkg::mem_idx_t);

  // Out-of-range store tags fall back to tag 0
  function automatic scratchpad_pkg::tag_t clamp_st_tag(input scratchpad_pkg::tag_t raw);
    if (int'(raw) >= NTAG) begin
      return '0;
    end
    return raw;
  endfunction

  // --------------------------------------------------
  // Tag split
  // --------------------------------------------------
  scratchpad_pkg::tag_t     ld_tag;
  scratchpad_pkg::tag_t     st_addr_tag;
  scratchpad_pkg::tag_t     st_data_tag;
  scratchpad_pkg::mem_idx_t ld_idx;
  scratchpad_pkg::elem_t    rd_data;

  assign ld_tag      = ld_addr_data[AW +: `SP_TAG_WIDTH];
  assign ld_idx      = ld_addr_data[IDX_W-1:0];
  assign st_addr_tag = st_addr_data[AW +: `SP_TAG_WIDTH];
  assign st_data_tag = st_data_data[EW +: `SP_TAG_WIDTH];

  // --------------------------------------------------
  // Load path, zero latency
  // --------------------------------------------------
  assign ld_addr_ready = ld_addr_valid && ld_data_ready && ld_done_ready;
  assign ld_data_valid = ld_addr_valid;
  assign ld_done_valid = ld_addr_valid;
  assign ld_data_data  = {ld_tag, rd_data};
  assign ld_done_data  = ld_tag;

  // --------------------------------------------------
  // Store queues and pairing
  // --------------------------------------------------
  logic [NTAG-1:0]                     addr_present;
  logic [NTAG-1:0]                     data_present;
  logic [NTAG-1:0]                     pop;
  scratchpad_pkg::mem_idx_t [NTAG-1:0] addr_heads;
  scratchpad_pkg::elem_t [NTAG-1:0]    data_heads;
  logic                                wr_en;
  scratchpad_pkg::mem_idx_t            wr_idx;
  scratchpad_pkg::elem_t               wr_data;
  logic                                deadlock;

  tagged_store_queue #(.payload_t(scratchpad_pkg::mem_idx_t)) i_addr_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (st_addr_valid),
    .push_tag     (clamp_st_tag(st_addr_tag)),
    .push_payload (st_addr_data[IDX_W-1:0]),
    .pop          (pop),
    .push_ready   (st_addr_ready),
    .head_present (addr_present),
    .head_payload (addr_heads)
  );

  tagged_store_queue #(.payload_t(scratchpad_pkg::elem_t)) i_data_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (st_data_valid),
    .push_tag     (clamp_st_tag(st_data_tag)),
    .push_payload (st_data_data[EW-1:0]),
    .pop          (pop),
    .push_ready   (st_data_ready),
    .head_present (data_present),
    .head_payload (data_heads)
  );

  store_pair_unit i_store_pair_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .addr_present  (addr_present),
    .data_present  (data_present),
    .addr_heads    (addr_heads),
    .data_heads    (data_heads),
    .st_done_ready (st_done_ready),
    .pop           (pop),
    .st_done_valid (st_done_valid),
    .st_done_data  (st_done_data),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .deadlock      (deadlock)
  );

  scratchpad_mem i_scratchpad_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data),
    .rd_idx  (ld_idx),
    .rd_data (rd_data)
  );

  // Raw tags go to the monitor so clamped stores are still flagged
  mem_error_monitor i_mem_error_monitor (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_valid      (ld_addr_valid),
    .ld_tag        (ld_tag),
    .st_addr_valid (st_addr_valid),
    .st_addr_tag   (st_addr_tag),
    .st_data_valid (st_data_valid),
    .st_data_tag   (st_data_tag),
    .deadlock      (deadlock),
    .error_valid   (error_valid),
    .error_code    (error_code)
  );

endmodule

`default_nettype wire

/* store_pair_unit.sv */
`timescale 1ns/1ps

`include "scratchpad_cfg.svh"

`default_nettype none

module store_pair_unit (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic [`SP_ST_COUNT-1:0]                     addr_present,
  input  logic [`SP_ST_COUNT-1:0]                     data_present,
  input  scratchpad_pkg::mem_idx_t [`SP_ST_COUNT-1:0] addr_heads,
  input  scratchpad_pkg::elem_t [`SP_ST_COUNT-1:0]    data_heads,
  input  logic                                        st_done_ready,
  output logic [`SP_ST_COUNT-1:0]                     pop,
  output logic                                        st_done_valid,
  output scratchpad_pkg::tag_t                        st_done_data,
  output logic                                        wr_en,
  output scratchpad_pkg::mem_idx_t                    wr_idx,
  output scratchpad_pkg::elem_t                       wr_data,
  output logic                                        deadlock
);

  localparam int NTAG    = `SP_ST_COUNT;
  localparam int TIMEOUT = `SP_DEADLOCK_TIMEOUT;
  localparam int CNT_W   = $clog2(TIMEOUT + 1);

  logic [NTAG-1:0] pair_ready;
  logic [NTAG-1:0] dl_hit;

  assign pair_ready = addr_present & data_present;

  // --------------------------------------------------
  // Lowest ready tag wins, one pair per cycle
  // --------------------------------------------------
  always_comb begin
    st_done_valid = 1'b0;
    st_done_data  = '0;
    wr_idx        = '0;
    wr_data       = '0;
    // Walk downwards so the lowest tag is assigned last
    for (int t = NTAG - 1; t >= 0; t--) begin
      if (pair_ready[t]) begin
        st_done_valid = 1'b1;
        st_done_data  = scratchpad_pkg::tag_t'(t);
        wr_idx        = addr_heads[t];
        wr_data       = data_heads[t];
      end
    end
  end

  // Write and pop happen on the done transfer
  assign wr_en = st_done_valid && st_done_ready;

  always_comb begin
    pop = '0;
    for (int t = 0; t < NTAG; t++) begin
      pop[t] = wr_en && (st_done_data == scratchpad_pkg::tag_t'(t));
    end
  end

  // --------------------------------------------------
  // Deadlock watchdog per tag
  // --------------------------------------------------
  for (genvar t = 0; t < NTAG; t++) begin : g_watchdog
    logic [CNT_W-1:0] wait_cnt;
    logic             one_sided;

    // Only one half of the pair is queued
    assign one_sided = addr_present[t] ^ data_present[t];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wait_cnt <= '0;
      end else if (!one_sided) begin
        wait_cnt <= '0;
      end else if (wait_cnt != CNT_W'(TIMEOUT)) begin
        wait_cnt <= wait_cnt + CNT_W'(1);
      end
    end

    assign dl_hit[t] = (wait_cnt == CNT_W'(TIMEOUT));
  end

  assign deadlock = |dl_hit;

endmodule

`default_nettype wire

/* tagged_store_queue.sv */
`timescale 1ns/1ps

`include "scratchpad_cfg.svh"

`default_nettype none

module tagged_store_queue #(
  parameter type payload_t = scratchpad_pkg::elem_t
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push_valid,
  input  scratchpad_pkg::tag_t            push_tag,
  input  payload_t                        push_payload,
  input  logic [`SP_ST_COUNT-1:0]         pop,
  output logic                            push_ready,
  output logic [`SP_ST_COUNT-1:0]         head_present,
  output payload_t [`SP_ST_COUNT-1:0]     head_payload
);

  localparam int NTAG  = `SP_ST_COUNT;
  localparam int DEPTH = `SP_LSQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = PTR_W + 1;

  logic [NTAG-1:0] tag_hit;
  logic [NTAG-1:0] full;

  // --------------------------------------------------
  // One circular FIFO per store tag
  // --------------------------------------------------
  for (genvar t = 0; t < NTAG; t++) begin : g_tag
    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_en;
    logic             pop_en;

    assign tag_hit[t] = (push_tag == scratchpad_pkg::tag_t'(t));
    assign full[t]    = (count == CNT_W'(DEPTH));
    assign push_en    = push_valid && tag_hit[t] && !full[t];
    // A pop of an empty FIFO is ignored
    assign pop_en     = pop[t] && (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push_en) begin
          wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
        end
        if (pop_en) begin
          rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
        end
        // Count holds when push and pop land together
        case ({push_en, pop_en})
          2'b10:   count <= count + CNT_W'(1);
          2'b01:   count <= count - CNT_W'(1);
          default: count <= count;
        endcase
      end
    end

    always_ff @(posedge clk) begin
      if (push_en) begin
        slots[wr_ptr] <= push_payload;
      end
    end

    assign head_present[t] = (count != '0);
    assign head_payload[t] = slots[rd_ptr];
  end

  // --------------------------------------------------
  // Ready follows the target tag only, never push_valid
  // --------------------------------------------------
  always_comb begin
    push_ready = 1'b0;
    for (int t = 0; t < NTAG; t++) begin
      if (tag_hit[t]) begin
        push_ready = !full[t];
      end
    end
  end

endmodule

`default_nettype wire

/* tb_scratchpad.sv */
`timescale 1ns/1ps

`include "scratchpad_cfg.svh"

`default_nettype none

module tb_scratchpad;

  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 10;
  localparam int SAMPLE_DLY  = 5;
  localparam int WAIT_LIMIT  = 50;
  localparam int TEST_COUNT  = 5;
  localparam int TEST_BUDGET = 300;
  localparam int IDX_W       = $clog2(`SP_MEM_DEPTH);
  localparam int PAD_W       = `SP_ADDR_WIDTH - IDX_W;
  localparam int NUM_TAGS    = 1 << `SP_TAG_WIDTH;
  // Upper address bits carry junk that the index ignores
  localparam logic [PAD_W-1:0] ADDR_PAD = PAD_W'(32'h2a5);

  logic                                    clk = 1'b0;
  logic                                    rst_n;
  logic                                    ld_addr_valid;
  logic                                    ld_addr_ready;
  logic [`SP_TAG_WIDTH+`SP_ADDR_WIDTH-1:0] ld_addr_data;
  logic                                    ld_data_valid;
  logic                                    ld_data_ready;
  logic [`SP_TAG_WIDTH+`SP_ELEM_WIDTH-1:0] ld_data_data;
  logic                                    ld_done_valid;
  logic                                    ld_done_ready;
  scratchpad_pkg::tag_t                    ld_done_data;
  logic                                    st_addr_valid;
  logic                                    st_addr_ready;
  logic [`SP_TAG_WIDTH+`SP_ADDR_WIDTH-1:0] st_addr_data;
  logic                                    st_data_valid;
  logic                                    st_data_ready;
  logic [`SP_TAG_WIDTH+`SP_ELEM_WIDTH-1:0] st_data_data;
  logic                                    st_done_valid;
  logic                                    st_done_ready;
  scratchpad_pkg::tag_t                    st_done_data;
  logic                                    error_valid;
  scratchpad_pkg::err_code_t               error_code;

  // Reference model with queues indexed by the full tag
  scratchpad_pkg::elem_t ref_mem [`SP_MEM_DEPTH];
  logic [IDX_W-1:0]      pend_addr [NUM_TAGS][$];
  scratchpad_pkg::elem_t pend_data [NUM_TAGS][$];
  scratchpad_pkg::tag_t  done_log [$];
  logic [31:0]           lcg_state;

  scratchpad_top i_scratchpad_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_addr_valid (ld_addr_valid),
    .ld_addr_ready (ld_addr_ready),
    .ld_addr_data  (ld_addr_data),
    .ld_data_valid (ld_data_valid),
    .ld_data_ready (ld_data_ready),
    .ld_data_data  (ld_data_data),
    .ld_done_valid (ld_done_valid),
    .ld_done_ready (ld_done_ready),
    .ld_done_data  (ld_done_data),
    .st_addr_valid (st_addr_valid),
    .st_addr_ready (st_addr_ready),
    .st_addr_data  (st_addr_data),
    .st_data_valid (st_data_valid),
    .st_data_ready (st_data_ready),
    .st_data_data  (st_data_data),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready),
    .st_done_data  (st_done_data),
    .error_valid   (error_valid),
    .error_code    (error_code)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // Checking and reporting
  // --------------------------------------------------
  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic scratchpad_pkg::elem_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic bit stores_pending();
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (pend_addr[t].size() != 0 || pend_data[t].size() != 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // --------------------------------------------------
  // Drivers entered on a falling edge
  // --------------------------------------------------
  task automatic idle_inputs();
    ld_addr_valid = 1'b0;
    ld_addr_data  = '0;
    ld_data_ready = 1'b0;
    ld_done_ready = 1'b0;
    st_addr_valid = 1'b0;
    st_addr_data  = '0;
    st_data_valid = 1'b0;
    st_data_data  = '0;
    st_done_ready = 1'b0;
  endtask

  task automatic apply_reset();
    idle_inputs();
    rst_n = 1'b0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      pend_addr[scratchpad_pkg::tag_t'(t)].delete();
      pend_data[scratchpad_pkg::tag_t'(t)].delete();
    end
    done_log.delete();
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic push_addr(input scratchpad_pkg::tag_t tag, input logic [IDX_W-1:0] idx);
    int waited;
    waited = 0;
    st_addr_valid = 1'b1;
    st_addr_data  = {tag, ADDR_PAD, idx};
    #(SAMPLE_DLY);
    while (!st_addr_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("store address on tag %0d was never accepted", tag);
        abort_run();
      end
      @(negedge clk);
      #(SAMPLE_DLY);
    end
    pend_addr[tag].push_back(idx);
    @(negedge clk);
    st_addr_valid = 1'b0;
  endtask

  task automatic push_data(input scratchpad_pkg::tag_t tag, input scratchpad_pkg::elem_t word);
    int waited;
    waited = 0;
    st_data_valid = 1'b1;
    st_data_data  = {tag, word};
    #(SAMPLE_DLY);
    while (!st_data_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("store data on tag %0d was never accepted", tag);
        abort_run();
      end
      @(negedge clk);
      #(SAMPLE_DLY);
    end
    pend_data[tag].push_back(word);
    @(negedge clk);
    st_data_valid = 1'b0;
  endtask

  // Pairs complete in queue order per tag
  task automatic watch_store_done();
    scratchpad_pkg::tag_t t;
    forever begin
      @(negedge clk);
      #(SAMPLE_DLY);
      if (rst_n && st_done_valid && st_done_ready) begin
        t = st_done_data;
        if (pend_addr[t].size() == 0 || pend_data[t].size() == 0) begin
          $display("store done on tag %0d without a queued address and data", t);
          abort_run();
        end
        ref_mem[pend_addr[t].pop_front()] = pend_data[t].pop_front();
        done_log.push_back(t);
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (stores_pending()) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("queued stores did not complete in time");
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic do_load(input scratchpad_pkg::tag_t tag, input logic [IDX_W-1:0] idx);
    ld_addr_valid = 1'b1;
    ld_data_ready = 1'b1;
    ld_done_ready = 1'b1;
    ld_addr_data  = {tag, ADDR_PAD, idx};
    #(SAMPLE_DLY);
    check_value("ld_addr_ready", 64'(ld_addr_ready), 64'd1);
    check_value("ld_data_valid", 64'(ld_data_valid), 64'd1);
    check_value("ld_data_data", 64'(ld_data_data), 64'({tag, ref_mem[idx]}));
    check_value("ld_done_valid", 64'(ld_done_valid), 64'd1);
    check_value("ld_done_data", 64'(ld_done_data), 64'(tag));
    @(negedge clk);
    ld_addr_valid = 1'b0;
  endtask

  task automatic check_error(input logic exp_valid, input scratchpad_pkg::err_code_t exp_code);
    #(SAMPLE_DLY);
    check_value("error_valid", 64'(error_valid), 64'(exp_valid));
    check_value("error_code", 64'(error_code), 64'(exp_code));
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic store_then_load();
    logic [IDX_W-1:0] used [$];
    logic [IDX_W-1:0] idx;
    apply_reset();
    st_done_ready = 1'b1;
    for (int i = 0; i < 2 * `SP_LSQ_DEPTH; i++) begin
      idx = IDX_W'(i * 7 + 2);
      used.push_back(idx);
      fork
        push_addr(scratchpad_pkg::tag_t'(i % `SP_ST_COUNT), idx);
        push_data(scratchpad_pkg::tag_t'(i % `SP_ST_COUNT), next_random());
      join
    end
    wait_drain();
    check_value("store done count", 64'(done_log.size()), 64'(2 * `SP_LSQ_DEPTH));
    foreach (used[k]) begin
      for (int t = 0; t < `SP_LD_COUNT; t++) begin
        do_load(scratchpad_pkg::tag_t'(t), used[k]);
      end
    end
    check_error(1'b0, scratchpad_pkg::ERR_NONE);
  endtask

  task automatic out_of_order_pairing();
    apply_reset();
    st_done_ready = 1'b1;
    // Tag 1 sends data first and tag 0 sends address first so both complete together
    fork
      begin
        push_data(2'd1, next_random());
        push_data(2'd0, next_random());
      end
      begin
        push_addr(2'd0, IDX_W'(40));
        push_addr(2'd1, IDX_W'(41));
      end
    join
    wait_drain();
    check_value("store done count", 64'(done_log.size()), 64'd2);
    check_value("first done tag", 64'(done_log[0]), 64'd0);
    check_value("second done tag", 64'(done_log[1]), 64'd1);
    do_load(2'd0, IDX_W'(40));
    do_load(2'd2, IDX_W'(41));
    check_error(1'b0, scratchpad_pkg::ERR_NONE);
  endtask

  task automatic back_pressure();
    apply_reset();
    for (int i = 0; i < `SP_LSQ_DEPTH; i++) begin
      fork
        push_addr(2'd0, IDX_W'(48 + i));
        push_data(2'd0, next_random());
      join
    end
    // Tag 0 is full in both queues
    st_addr_valid = 1'b1;
    st_addr_data  = {2'd0, ADDR_PAD, IDX_W'(60)};
    st_data_valid = 1'b1;
    st_data_data  = {2'd0, next_random()};
    #(SAMPLE_DLY);
    check_value("st_addr_ready on full tag", 64'(st_addr_ready), 64'd0);
    check_value("st_data_ready on full tag", 64'(st_data_ready), 64'd0);
    check_value("st_done_valid", 64'(st_done_valid), 64'd1);
    check_value("st_done_data", 64'(st_done_data), 64'd0);
    @(negedge clk);
    st_addr_valid = 1'b0;
    st_data_valid = 1'b0;
    fork
      push_addr(2'd1, IDX_W'(62));
      push_data(2'd1, next_random());
    join
    check_value("dones under back-pressure", 64'(done_log.size()), 64'd0);
    st_done_ready = 1'b1;
    wait_drain();
    check_value("store done count", 64'(done_log.size()), 64'(`SP_LSQ_DEPTH + 1));
    for (int i = 0; i < `SP_LSQ_DEPTH; i++) begin
      check_value("done tag order", 64'(done_log[i]), 64'd0);
      do_load(2'd2, IDX_W'(48 + i));
    end
    check_value("last done tag", 64'(done_log[`SP_LSQ_DEPTH]), 64'd1);
    do_load(2'd0, IDX_W'(62));
  endtask

  task automatic tag_out_of_range();
    apply_reset();
    ld_addr_valid = 1'b1;
    ld_data_ready = 1'b1;
    ld_done_ready = 1'b1;
    ld_addr_data  = {2'd3, ADDR_PAD, IDX_W'(0)};
    @(negedge clk);
    ld_addr_valid = 1'b0;
    check_error(1'b1, scratchpad_pkg::ERR_TAG_OOB);
    // Clean traffic leaves the first error in place
    st_done_ready = 1'b1;
    fork
      push_addr(2'd0, IDX_W'(5));
      push_data(2'd0, next_random());
    join
    wait_drain();
    do_load(2'd1, IDX_W'(5));
    check_error(1'b1, scratchpad_pkg::ERR_TAG_OOB);
    apply_reset();
    st_addr_valid = 1'b1;
    st_addr_data  = {2'd2, ADDR_PAD, IDX_W'(0)};
    @(negedge clk);
    st_addr_valid = 1'b0;
    check_error(1'b1, scratchpad_pkg::ERR_TAG_OOB);
  endtask

  task automatic store_deadlock();
    apply_reset();
    push_addr(2'd1, IDX_W'(20));
    repeat (`SP_DEADLOCK_TIMEOUT - 2) @(negedge clk);
    check_error(1'b0, scratchpad_pkg::ERR_NONE);
    repeat (4) @(negedge clk);
    check_error(1'b1, scratchpad_pkg::ERR_STORE_DEADLOCK);
    apply_reset();
    st_done_ready = 1'b1;
    push_addr(2'd1, IDX_W'(21));
    repeat (3) @(negedge clk);
    push_data(2'd1, next_random());
    wait_drain();
    repeat (`SP_DEADLOCK_TIMEOUT + 4) @(negedge clk);
    check_error(1'b0, scratchpad_pkg::ERR_NONE);
    do_load(2'd0, IDX_W'(21));
  endtask

  // --------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------
  initial begin
    lcg_state = 32'd38539;
    fork
      watch_store_done();
    join_none
    apply_reset();
    store_then_load();
    out_of_order_pairing();
    back_pressure();
    tag_out_of_range();
    store_deadlock();
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * TEST_BUDGET * (TEST_COUNT + 1));
    $display("watchdog expired before the tests finished");
    abort_run();
  end

endmodule

`default_nettype wire
